//--- mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // ##############################
    // Data path widths
    // ##############################

    localparam int reg_width  = 64; // Load and store data
    localparam int addr_width = 64; // Load and store addresses
    localparam int kb_width   = 8;  // One keyboard scan code
    localparam int swt_width  = 8;
    localparam int seg_width  = 32; // Eight hex digits on the seven-segment display
    localparam int led_width  = 16;
    localparam int rtc_width  = 64; // Microseconds since reset

    // ##############################
    // Address map
    // ##############################

    // Data RAM window, aligned to its own size
    localparam logic [31:0] ram_base = 32'h8000_0000;
    localparam logic [31:0] ram_len  = 32'd4096;     // Bytes
    localparam int ram_index_width   = 9;            // Doubleword index into ram_len

    // Each peripheral owns one doubleword
    localparam logic [31:0] kbd_addr = 32'ha000_0060; // Read pops one scan code
    localparam logic [31:0] swt_addr = 32'ha000_0070;
    localparam logic [31:0] rtc_addr = 32'ha000_0048;
    localparam logic [31:0] seg_addr = 32'ha000_0080; // Write only
    localparam logic [31:0] led_addr = 32'ha000_0090; // Write only
    localparam logic [31:0] peri_len = 32'd8;

    // ##############################
    // Store width codes
    // ##############################

    localparam int wdt_width = 2;

    localparam logic [wdt_width-1:0] wdt_byte  = 2'd0;
    localparam logic [wdt_width-1:0] wdt_half  = 2'd1;
    localparam logic [wdt_width-1:0] wdt_word  = 2'd2;
    localparam logic [wdt_width-1:0] wdt_dword = 2'd3;

    // Peripheral sizing
    localparam int kbd_depth   = 8;  // Scan codes held before new ones are dropped
    localparam int clks_per_us = 25; // Cycles of the 40 ns clock in one microsecond

    // One RAM doubleword, seen whole or as byte lanes
    // Lane 0 is the least significant byte
    typedef union packed {
        logic [reg_width-1:0]          dword;
        logic [reg_width/8-1:0][7:0]   lanes;
    } mem_word_u;

endpackage

`default_nettype wire

//--- data_ram.sv
`default_nettype none
`timescale 1ns/1ps

module data_ram (
    input  wire                                   clk,
    input  wire [mmio_pkg::ram_index_width-1:0]   raddr_index,
    input  wire [mmio_pkg::ram_index_width-1:0]   waddr_index,
    input  wire [2:0]                             byte_off,    // First lane written
    input  wire                                   wen,
    input  wire [mmio_pkg::wdt_width-1:0]         wdt_op,
    input  wire [mmio_pkg::reg_width-1:0]         wdata,
    output logic [mmio_pkg::reg_width-1:0]        rdata
);

    mmio_pkg::mem_word_u mem [2**mmio_pkg::ram_index_width]; // Contents are undefined after reset

    mmio_pkg::mem_word_u shifted;   // Store data moved up to its first lane
    logic [7:0]          lane_bits; // Lanes covered by the store width, from lane 0
    logic [7:0]          lane_mask; // Lanes actually written

    // ##############################
    // Read port
    // ##############################

    // Whole doubleword, the core picks out the lanes it wants
    assign rdata = mem[raddr_index].dword;

    // ##############################
    // Write port
    // ##############################

    always_comb begin
        case (wdt_op)
            mmio_pkg::wdt_byte: lane_bits = 8'h01;
            mmio_pkg::wdt_half: lane_bits = 8'h03;
            mmio_pkg::wdt_word: lane_bits = 8'h0f;
            default:            lane_bits = 8'hff; // Doubleword
        endcase
    end

    // Bytes that would land past lane 7 fall off the top of both shifts
    assign lane_mask     = lane_bits << byte_off;
    assign shifted.dword = wdata << {byte_off, 3'b000};

    always_ff @(posedge clk) begin
        if (wen) begin
            for (int i = 0; i < 8; i++) begin
                if (lane_mask[i]) begin
                    mem[waddr_index].lanes[i] <= shifted.lanes[i];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- kbd_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module kbd_fifo (
    input  wire                             clk,
    input  wire                             reset,
    input  wire [mmio_pkg::kb_width-1:0]    push_code,
    input  wire                             push_valid,
    input  wire                             pop,
    output logic [mmio_pkg::kb_width-1:0]   head_code,
    output logic                            not_empty
);

    logic [mmio_pkg::kb_width-1:0]            buffer [mmio_pkg::kbd_depth];
    logic [$clog2(mmio_pkg::kbd_depth)-1:0]   wr_ptr;
    logic [$clog2(mmio_pkg::kbd_depth)-1:0]   rd_ptr;
    logic [$clog2(mmio_pkg::kbd_depth+1)-1:0] fill;   // Codes currently held

    logic push_ok;
    logic pop_ok;

    // A full queue drops the incoming code, even when a pop frees a slot this cycle
    assign push_ok = push_valid && (fill != mmio_pkg::kbd_depth);
    assign pop_ok  = pop && not_empty;

    assign not_empty = (fill != '0);
    assign head_code = buffer[rd_ptr]; // Oldest code, valid while not_empty

    always_ff @(posedge clk) begin
        if (push_ok) begin
            buffer[wr_ptr] <= push_code;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == mmio_pkg::kbd_depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == mmio_pkg::kbd_depth - 1) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leaves the fill level alone
            case ({push_ok, pop_ok})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- rtc_counter.sv
`default_nettype none
`timescale 1ns/1ps

module rtc_counter (
    input  wire                               clk,
    input  wire                               reset,
    output logic [mmio_pkg::rtc_width-1:0]    count   // Microseconds since reset
);

    logic [$clog2(mmio_pkg::clks_per_us)-1:0] prescale;
    logic                                     tick;

    // One pulse on the last cycle of every microsecond
    assign tick = (prescale == mmio_pkg::clks_per_us - 1);

    always_ff @(posedge clk) begin
        if (reset) begin
            prescale <= '0;
            count    <= '0;
        end else begin
            if (tick) begin
                prescale <= '0;
                count    <= count + 1'b1; // Wraps only after several hundred thousand years
            end else begin
                prescale <= prescale + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- mmio.sv
`default_nettype none
`timescale 1ns/1ps

module mmio (
    input  wire                                   clk,
    input  wire                                   reset,
    input  wire [mmio_pkg::addr_width-1:0]        mem_raddr,
    input  wire [mmio_pkg::addr_width-1:0]        mem_waddr,
    input  wire [mmio_pkg::reg_width-1:0]         mem_wdata,
    input  wire                                   mem_wen,
    input  wire                                   mem_ren,
    input  wire [mmio_pkg::wdt_width-1:0]         wdt_op,
    input  wire [mmio_pkg::reg_width-1:0]         ram_rdata,
    input  wire [mmio_pkg::kb_width-1:0]          kb_rdata,  // Head of the keyboard queue
    input  wire                                   kb_ready,
    input  wire [mmio_pkg::swt_width-1:0]         swt_rdata,
    input  wire [mmio_pkg::rtc_width-1:0]         rtc_count,
    output logic [mmio_pkg::reg_width-1:0]        mem_rdata,
    output logic                                  sig_rd_kb, // Pops the queue at the next edge
    output logic [mmio_pkg::ram_index_width-1:0]  ram_raddr_index,
    output logic [mmio_pkg::ram_index_width-1:0]  ram_waddr_index,
    output logic [2:0]                            ram_byte_off,
    output logic                                  ram_wen,
    output logic [mmio_pkg::reg_width-1:0]        ram_wdata,
    output logic [mmio_pkg::wdt_width-1:0]        ram_wdt_op,
    output logic [mmio_pkg::seg_width-1:0]        seg_wdata,
    output logic [mmio_pkg::led_width-1:0]        led_wdata
);

    // True when addr falls in [base, base + len)
    function automatic logic in_window(
        input logic [mmio_pkg::addr_width-1:0] addr,
        input logic [mmio_pkg::addr_width-1:0] base,
        input logic [mmio_pkg::addr_width-1:0] len
    );
        return (addr >= base) && (addr < base + len);
    endfunction

    logic rd_ram;
    logic wr_ram;

    assign rd_ram = in_window(mem_raddr, mmio_pkg::ram_base, mmio_pkg::ram_len);
    assign wr_ram = in_window(mem_waddr, mmio_pkg::ram_base, mmio_pkg::ram_len);

    // ##############################
    // Load path
    // ##############################

    // The RAM window is aligned, so the index comes straight from the address bits
    assign ram_raddr_index = mem_raddr[3 +: mmio_pkg::ram_index_width];

    always_comb begin
        mem_rdata = '0; // Unmapped and write-only addresses read zero
        sig_rd_kb = 1'b0;
        if (mem_ren) begin
            if (rd_ram) begin
                mem_rdata = ram_rdata;
            end else if (in_window(mem_raddr, mmio_pkg::kbd_addr, mmio_pkg::peri_len)) begin
                // An empty queue reads zero and nothing is popped
                if (kb_ready) begin
                    sig_rd_kb                          = 1'b1;
                    mem_rdata[mmio_pkg::kb_width-1:0]  = kb_rdata;
                end
            end else if (in_window(mem_raddr, mmio_pkg::swt_addr, mmio_pkg::peri_len)) begin
                mem_rdata[mmio_pkg::swt_width-1:0] = swt_rdata;
            end else if (in_window(mem_raddr, mmio_pkg::rtc_addr, mmio_pkg::peri_len)) begin
                mem_rdata[mmio_pkg::rtc_width-1:0] = rtc_count;
            end
        end
    end

    // ##############################
    // Store path
    // ##############################

    assign ram_waddr_index = mem_waddr[3 +: mmio_pkg::ram_index_width];
    assign ram_byte_off    = mem_waddr[2:0];
    assign ram_wen         = mem_wen && wr_ram;
    assign ram_wdata       = mem_wdata;
    assign ram_wdt_op      = wdt_op;

    // Output registers take the low bits of the store whatever its width code
    always_ff @(posedge clk) begin
        if (reset) begin
            seg_wdata <= '0;
            led_wdata <= '0;
        end else if (mem_wen) begin
            if (in_window(mem_waddr, mmio_pkg::seg_addr, mmio_pkg::peri_len)) begin
                seg_wdata <= mem_wdata[mmio_pkg::seg_width-1:0];
            end else if (in_window(mem_waddr, mmio_pkg::led_addr, mmio_pkg::peri_len)) begin
                led_wdata <= mem_wdata[mmio_pkg::led_width-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- io_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module io_subsystem (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [mmio_pkg::addr_width-1:0]    mem_raddr,
    input  wire [mmio_pkg::addr_width-1:0]    mem_waddr,
    input  wire [mmio_pkg::reg_width-1:0]     mem_wdata,
    input  wire                               mem_wen,
    input  wire                               mem_ren,
    input  wire [mmio_pkg::wdt_width-1:0]     wdt_op,
    input  wire [mmio_pkg::kb_width-1:0]      kb_code,       // Ready-made scan code
    input  wire                               kb_code_valid,
    input  wire [mmio_pkg::swt_width-1:0]     swt_rdata,
    output wire [mmio_pkg::reg_width-1:0]     mem_rdata,
    output wire [mmio_pkg::seg_width-1:0]     seg_wdata,
    output wire [mmio_pkg::led_width-1:0]     led_wdata
);

    // RAM port
    wire [mmio_pkg::ram_index_width-1:0] ram_raddr_index;
    wire [mmio_pkg::ram_index_width-1:0] ram_waddr_index;
    wire [2:0]                           ram_byte_off;
    wire                                 ram_wen;
    wire [mmio_pkg::reg_width-1:0]       ram_wdata;
    wire [mmio_pkg::wdt_width-1:0]       ram_wdt_op;
    wire [mmio_pkg::reg_width-1:0]       ram_rdata;

    // Keyboard queue and timer
    wire [mmio_pkg::kb_width-1:0]        kb_rdata;
    wire                                 kb_ready;
    wire                                 sig_rd_kb;
    wire [mmio_pkg::rtc_width-1:0]       rtc_count;

    // ##############################
    // Address decoder
    // ##############################

    mmio mmio_i (
        .clk             (clk),
        .reset           (reset),
        .mem_raddr       (mem_raddr),
        .mem_waddr       (mem_waddr),
        .mem_wdata       (mem_wdata),
        .mem_wen         (mem_wen),
        .mem_ren         (mem_ren),
        .wdt_op          (wdt_op),
        .ram_rdata       (ram_rdata),
        .kb_rdata        (kb_rdata),
        .kb_ready        (kb_ready),
        .swt_rdata       (swt_rdata),
        .rtc_count       (rtc_count),
        .mem_rdata       (mem_rdata),
        .sig_rd_kb       (sig_rd_kb),
        .ram_raddr_index (ram_raddr_index),
        .ram_waddr_index (ram_waddr_index),
        .ram_byte_off    (ram_byte_off),
        .ram_wen         (ram_wen),
        .ram_wdata       (ram_wdata),
        .ram_wdt_op      (ram_wdt_op),
        .seg_wdata       (seg_wdata),
        .led_wdata       (led_wdata)
    );

    // ##############################
    // Sources and sinks
    // ##############################

    data_ram data_ram_i (
        .clk         (clk),
        .raddr_index (ram_raddr_index),
        .waddr_index (ram_waddr_index),
        .byte_off    (ram_byte_off),
        .wen         (ram_wen),
        .wdt_op      (ram_wdt_op),
        .wdata       (ram_wdata),
        .rdata       (ram_rdata)
    );

    kbd_fifo kbd_fifo_i (
        .clk        (clk),
        .reset      (reset),
        .push_code  (kb_code),
        .push_valid (kb_code_valid),
        .pop        (sig_rd_kb),
        .head_code  (kb_rdata),
        .not_empty  (kb_ready)
    );

    rtc_counter rtc_counter_i (
        .clk   (clk),
        .reset (reset),
        .count (rtc_count)
    );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    // Synchronous reset held over the first 8 rising edges
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

//--- tb_io_subsystem.sv
`default_nettype none
`timescale 1ns/1ps

module tb_io_subsystem;

    localparam int max_cycles = 5000; // All tests together take a little over 1100 cycles
    localparam int ram_words  = mmio_pkg::ram_len / 8;
    localparam int rtc_gap    = 250;  // Cycles between the two timer samples
    localparam int rtc_step   = rtc_gap / mmio_pkg::clks_per_us; // Microseconds in that gap

    logic        clk;
    logic        reset;
    logic [63:0] mem_raddr;
    logic [63:0] mem_waddr;
    logic [63:0] mem_wdata;
    logic        mem_wen;
    logic        mem_ren;
    logic [1:0]  wdt_op;
    logic [7:0]  kb_code;
    logic        kb_code_valid;
    logic [7:0]  swt_rdata;
    wire  [63:0] mem_rdata;
    wire  [31:0] seg_wdata;
    wire  [15:0] led_wdata;

    integer              seed = 32'h903a_c2c2;
    mmio_pkg::mem_word_u ram_model [ram_words]; // What the RAM should hold
    logic [7:0]          kbd_expected [$];      // Codes pushed and not yet read
    logic [31:0]         seg_model = '0;
    logic [15:0]         led_model = '0;
    int error_count = 0;
    int check_count = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int cycle_count = 0;

    tb_clock_gen clock_gen_i (.clk(clk), .reset(reset));

    io_subsystem io_subsystem_i (
        .clk(clk), .reset(reset), .mem_raddr(mem_raddr), .mem_waddr(mem_waddr),
        .mem_wdata(mem_wdata), .mem_wen(mem_wen), .mem_ren(mem_ren), .wdt_op(wdt_op),
        .kb_code(kb_code), .kb_code_valid(kb_code_valid), .swt_rdata(swt_rdata),
        .mem_rdata(mem_rdata), .seg_wdata(seg_wdata), .led_wdata(led_wdata)
    );

    // Idle load port must read zero
    assert property (@(posedge clk) disable iff (reset) (!mem_ren |-> mem_rdata == '0))
        else begin
            error_count++;
            $display("ERROR: time %0t signal mem_rdata expected 0x0 actual 0x%h",
                     $time, $sampled(mem_rdata));
        end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("Run stopped: simulation timed out after %0d cycles", cycle_count);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // ##############################
    // Helpers
    // ##############################

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("ERROR: time %0t signal %s expected 0x%h actual 0x%h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic store(input logic [31:0] addr, input logic [63:0] data,
                         input logic [1:0] width);
        @(posedge clk);
        mem_wen   <= 1'b1;
        mem_waddr <= {32'h0, addr};
        mem_wdata <= data;
        wdt_op    <= width;
        @(posedge clk);           // Store takes effect here
        mem_wen   <= 1'b0;
    endtask

    task automatic load(input logic [31:0] addr, output logic [63:0] data);
        @(posedge clk);
        mem_ren   <= 1'b1;
        mem_raddr <= {32'h0, addr};
        @(negedge clk);
        data = mem_rdata;
        @(posedge clk);
        mem_ren   <= 1'b0;
    endtask

    // Lane k of the store goes to lane offset + k, and lanes past 7 are lost
    function automatic void model_store(input logic [31:0] addr, input logic [63:0] data,
                                        input logic [1:0] width);
        int nbytes;
        int index;
        int lane;
        case (width)
            mmio_pkg::wdt_byte: nbytes = 1;
            mmio_pkg::wdt_half: nbytes = 2;
            mmio_pkg::wdt_word: nbytes = 4;
            default:            nbytes = 8;
        endcase
        index = (addr - mmio_pkg::ram_base) / 8;
        for (int k = 0; k < nbytes; k++) begin
            lane = addr[2:0] + k;
            if (lane < 8) ram_model[index].lanes[lane] = data[8*k +: 8];
        end
    endfunction

    function automatic logic [31:0] random_dword_addr();
        return mmio_pkg::ram_base + ($random(seed) & (mmio_pkg::ram_len - 8));
    endfunction

    task automatic push_codes(input int count);
        logic [7:0] code;
        for (int i = 0; i < count; i++) begin
            code = 8'h80 | 8'($random(seed)); // Never zero, so distinct from an empty read
            @(posedge clk);
            kb_code       <= code;
            kb_code_valid <= 1'b1;
            kbd_expected.push_back(code);
        end
        @(posedge clk);
        kb_code_valid <= 1'b0;
    endtask

    // Checks seg and led before and after the edge that performs the store
    task automatic store_and_watch(input logic [31:0] addr, input logic [63:0] data);
        @(posedge clk);
        mem_wen   <= 1'b1;
        mem_waddr <= {32'h0, addr};
        mem_wdata <= data;
        wdt_op    <= mmio_pkg::wdt_dword;
        @(negedge clk);
        check_value("seg_wdata", seg_model, seg_wdata);
        check_value("led_wdata", led_model, led_wdata);
        if (addr == mmio_pkg::seg_addr) seg_model = data[31:0];
        if (addr == mmio_pkg::led_addr) led_model = data[15:0];
        @(posedge clk);
        mem_wen <= 1'b0;
        @(negedge clk);
        check_value("seg_wdata", seg_model, seg_wdata);
        check_value("led_wdata", led_model, led_wdata);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // ##############################
    // Tests
    // ##############################

    initial begin
        logic [31:0] addrs [32];
        logic [31:0] quiet [6];
        logic [63:0] data;
        logic [63:0] got;
        logic [63:0] prev;
        logic [7:0]  sw;
        int          errors_before;
        mem_raddr = '0;
        mem_waddr = '0;
        mem_wdata = '0;
        mem_wen = 1'b0;
        mem_ren = 1'b0;
        wdt_op = '0;
        kb_code = '0;
        kb_code_valid = 1'b0;
        swt_rdata = '0;
        wait (reset === 1'b0);

        errors_before = error_count;
        for (int i = 0; i < 32; i++) begin
            addrs[i] = random_dword_addr();
            data = {$random(seed), $random(seed)};
            store(addrs[i], data, mmio_pkg::wdt_dword);
            model_store(addrs[i], data, mmio_pkg::wdt_dword);
        end
        for (int i = 0; i < 32; i++) begin
            load(addrs[i], got);
            check_value("mem_rdata", ram_model[(addrs[i] - mmio_pkg::ram_base) / 8].dword, got);
        end
        finish_test("1 doubleword stores", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 32; i++) begin
            addrs[0] = random_dword_addr();
            data = {$random(seed), $random(seed)};
            store(addrs[0], data, mmio_pkg::wdt_dword); // Defines every lane first
            model_store(addrs[0], data, mmio_pkg::wdt_dword);
            addrs[1] = addrs[0] + ($random(seed) & 7);
            data = {$random(seed), $random(seed)};
            wdt_op <= 2'({$random(seed)} % 3);
            @(negedge clk);
            store(addrs[1], data, wdt_op);
            model_store(addrs[1], data, wdt_op);
            load(addrs[0], got);
            check_value("mem_rdata", ram_model[(addrs[0] - mmio_pkg::ram_base) / 8].dword, got);
        end
        finish_test("2 partial stores", errors_before);

        errors_before = error_count;
        load(mmio_pkg::kbd_addr, got);
        check_value("mem_rdata", 64'h0, got);
        push_codes(5);
        while (kbd_expected.size() > 0) begin
            load(mmio_pkg::kbd_addr, got);
            check_value("mem_rdata", {56'h0, kbd_expected.pop_front()}, got);
        end
        load(mmio_pkg::kbd_addr, got);
        check_value("mem_rdata", 64'h0, got);
        push_codes(10);                  // Last two overflow the queue
        for (int i = 0; i < 10; i++) begin
            load(mmio_pkg::kbd_addr, got);
            data = (i < mmio_pkg::kbd_depth) ? {56'h0, kbd_expected.pop_front()} : 64'h0;
            check_value("mem_rdata", data, got);
        end
        kbd_expected.delete();
        finish_test("3 keyboard queue", errors_before);

        errors_before = error_count;
        for (int i = 0; i < 2; i++) begin
            sw = 8'($random(seed));
            if (i == 1) sw[7] = 1'b1; // Top bit set tells zero from sign extension
            @(posedge clk);
            swt_rdata <= sw;
            load(mmio_pkg::swt_addr, got);
            check_value("mem_rdata", {56'h0, sw}, got);
        end
        quiet = '{32'ha000_0000, 32'ha000_0050, 32'h0000_0000,
                  mmio_pkg::ram_base + mmio_pkg::ram_len, mmio_pkg::seg_addr, mmio_pkg::led_addr};
        for (int i = 0; i < 6; i++) begin
            load(quiet[i], got);
            check_value("mem_rdata", 64'h0, got);
        end
        finish_test("4 switches and unmapped loads", errors_before);

        errors_before = error_count;
        store_and_watch(mmio_pkg::seg_addr, {$random(seed), $random(seed)});
        store_and_watch(mmio_pkg::led_addr, {$random(seed), $random(seed)});
        store_and_watch(mmio_pkg::seg_addr, {$random(seed), $random(seed)});
        for (int i = 0; i < 4; i++) begin
            store_and_watch(i == 0 ? mmio_pkg::kbd_addr : quiet[i - 1], 64'hffff_ffff_ffff_ffff);
        end
        load(mmio_pkg::kbd_addr, got);  // Queue must still be empty
        check_value("mem_rdata", 64'h0, got);
        finish_test("5 output registers", errors_before);

        errors_before = error_count;
        load(mmio_pkg::rtc_addr, prev);
        repeat (rtc_gap - 2) @(posedge clk); // Samples land rtc_gap cycles apart
        load(mmio_pkg::rtc_addr, got);
        check_count++;
        assert (got - prev >= rtc_step - 1 && got - prev <= rtc_step + 1) else begin
            error_count++;
            $display("ERROR: time %0t signal rtc_count step expected %0d to %0d actual %0d",
                     $time, rtc_step - 1, rtc_step + 1, got - prev);
        end
        for (int i = 0; i < 20; i++) begin
            prev = got;
            repeat ({$random(seed)} % 32) @(posedge clk);
            load(mmio_pkg::rtc_addr, got);
            check_count++;
            assert (got >= prev) else begin
                error_count++;
                $display("ERROR: time %0t signal mem_rdata expected at least %0d actual %0d",
                         $time, prev, got);
            end
        end
        finish_test("6 microsecond counter", errors_before);

        $display("Tests run %0d, passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
mmio_pkg.sv
data_ram.sv
kbd_fifo.sv
rtc_counter.sv
mmio.sv
io_subsystem.sv
tb_clock_gen.sv
tb_io_subsystem.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_io_subsystem
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx "Simulation PASSED" $(LOG) || { echo "Pass message missing from $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
